// ==== vlog.f ====
+incdir+.
lc3b_mem_pkg.sv
mem_access_controller.sv
mem_data_path.sv
data_memory.sv
mem_stage.sv
tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory stage testbench with verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_stage \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q -F '*** PASSED ***' "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== tb_mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_stage_cfg.svh"

module tb_mem_stage import lc3b_mem_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int MAX_HOLD     = 4;
    localparam int ENTRY_CYCLES = MAX_HOLD + 4 * (`MEM_WAIT_STATES + 1) + 4;
    localparam int RAND_PAIRS   = 6;

    // one row of the stimulus table.
    typedef struct packed {
        lc3b_opcode op;
        lc3b_word   addr;
        lc3b_word   data;
        logic [2:0] hold;
        lc3b_word   exp;
        logic       chk;
    } entry_t;

    logic             clk;
    logic             rst_n;
    logic             ext_stall;
    lc3b_control_word control_in;
    lc3b_word         ir_in;
    lc3b_word         addr_in;
    lc3b_word         store_data;
    lc3b_word         load_data;
    logic             stall;

    entry_t                table_q[$];
    lc3b_word              ref_mem [`MEM_WORDS];
    logic [`MEM_WORDS-1:0] ref_retried = '0;
    logic                  table_built = 1'b0;
    integer                seed;
    int                    pass_count   = 0;
    int                    fail_count   = 0;
    int                    rty_expected = 0;
    int                    rty_seen     = 0;

    mem_stage UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .ext_stall  (ext_stall),
        .control_in (control_in),
        .ir_in      (ir_in),
        .addr_in    (addr_in),
        .store_data (store_data),
        .load_data  (load_data),
        .stall      (stall)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // count retries seen on the memory port.
    always @(negedge clk) begin
        if (rst_n && UUT.mem_rty) begin
            rty_seen = rty_seen + 1;
        end
    end

    // ****************************************
    // decode and reference model.
    // ****************************************
    function automatic lc3b_control_word control_for(input lc3b_opcode op);
        lc3b_control_word cw;
        cw = '0;
        cw.data_memory_addr_mux_sel = lc3b_data_memory_addr_mux_sel_alu;
        cw.data_memory_access       = op inside {op_ldr, op_ldb, op_ldi, op_str, op_stb, op_sti};
        cw.data_memory_write_enable = op inside {op_str, op_stb, op_sti};
        cw.byte_access              = op inside {op_ldb, op_stb};
        return cw;
    endfunction

    function automatic bit is_load(input lc3b_opcode op);
        return op inside {op_ldr, op_ldb, op_ldi};
    endfunction

    function automatic bit is_mem(input lc3b_opcode op);
        return op inside {op_ldr, op_ldb, op_ldi, op_str, op_stb, op_sti};
    endfunction

    function automatic string op_text(input lc3b_opcode op);
        case (op)
            op_ldr:  return "LDR";
            op_ldb:  return "LDB";
            op_ldi:  return "LDI";
            op_str:  return "STR";
            op_stb:  return "STB";
            op_sti:  return "STI";
            default: return "NOP";
        endcase
    endfunction

    function automatic int word_idx(input lc3b_word a);
        return int'(a >> 1) % `MEM_WORDS;
    endfunction

    // first touch of a word in the retry region costs one retry.
    task automatic note_access(input lc3b_word a);
        int i;
        i = word_idx(a);
        if (a[`MEM_RTY_ADDR_BIT] && !ref_retried[i]) begin
            ref_retried[i] = 1'b1;
            rty_expected   = rty_expected + 1;
        end
    endtask

    task automatic model_apply(input entry_t e, output lc3b_word result);
        lc3b_word   ptr;
        lc3b_word   w;
        logic [7:0] b;
        int         i;
        result = '0;
        ptr    = e.addr;
        // indirect ops fetch the pointer first.
        if (e.op == op_ldi || e.op == op_sti) begin
            note_access(e.addr);
            ptr = ref_mem[word_idx(e.addr)];
        end
        note_access(ptr);
        i = word_idx(ptr);
        w = ref_mem[i];
        b = ptr[0] ? w[15:8] : w[7:0];
        case (e.op)
            op_ldr, op_ldi: result = w;
            op_ldb:         result = {{8{b[7]}}, b};
            op_str, op_sti: ref_mem[i] = e.data;
            op_stb: begin
                if (ptr[0]) begin
                    ref_mem[i][15:8] = e.data[7:0];
                end else begin
                    ref_mem[i][7:0] = e.data[7:0];
                end
            end
            default: ;
        endcase
    endtask

    // ****************************************
    // stimulus table.
    // ****************************************
    task automatic add_entry(input lc3b_opcode op, input lc3b_word addr, input lc3b_word data,
                             input logic [2:0] hold, input lc3b_word exp, input logic chk);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.hold = hold;
        e.exp  = exp;
        e.chk  = chk;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] r;
        lc3b_word    a;
        lc3b_word    d;
        add_entry(op_add, 16'h0000, 16'h0000, 3'd0, 16'h0000, 1'b0);
        add_entry(op_str, 16'h0010, 16'h1234, 3'd0, 16'h0000, 1'b0);
        add_entry(op_str, 16'h0020, 16'hbeef, 3'd0, 16'h0000, 1'b0);
        add_entry(op_ldr, 16'h0010, 16'h0000, 3'd0, 16'h1234, 1'b1);
        add_entry(op_ldr, 16'h0020, 16'h0000, 3'd0, 16'hbeef, 1'b1);
        add_entry(op_str, 16'h0010, 16'h5678, 3'd2, 16'h0000, 1'b0);
        add_entry(op_ldr, 16'h0010, 16'h0000, 3'd0, 16'h5678, 1'b1);
        add_entry(op_jmp, 16'h0000, 16'h0000, 3'd0, 16'h0000, 1'b0);
        // byte lanes.
        add_entry(op_str, 16'h0030, 16'h0000, 3'd0, 16'h0000, 1'b0);
        add_entry(op_stb, 16'h0030, 16'h00a5, 3'd0, 16'h0000, 1'b0);
        add_entry(op_stb, 16'h0031, 16'h1c7f, 3'd0, 16'h0000, 1'b0);
        add_entry(op_ldr, 16'h0030, 16'h0000, 3'd0, 16'h7fa5, 1'b1);
        add_entry(op_ldb, 16'h0030, 16'h0000, 3'd0, 16'hffa5, 1'b1);
        add_entry(op_ldb, 16'h0031, 16'h0000, 3'd0, 16'h007f, 1'b1);
        add_entry(op_stb, 16'h0031, 16'h0080, 3'd1, 16'h0000, 1'b0);
        add_entry(op_ldb, 16'h0031, 16'h0000, 3'd0, 16'hff80, 1'b1);
        add_entry(op_ldr, 16'h0030, 16'h0000, 3'd0, 16'h80a5, 1'b1);
        // indirection.
        add_entry(op_str, 16'h0040, 16'h0050, 3'd0, 16'h0000, 1'b0);
        add_entry(op_str, 16'h0050, 16'hcafe, 3'd0, 16'h0000, 1'b0);
        add_entry(op_ldi, 16'h0040, 16'h0000, 3'd0, 16'hcafe, 1'b1);
        add_entry(op_sti, 16'h0040, 16'h4321, 3'd0, 16'h0000, 1'b0);
        add_entry(op_ldr, 16'h0050, 16'h0000, 3'd0, 16'h4321, 1'b1);
        // retry region, some with back-pressure.
        add_entry(op_str, 16'h0120, 16'h9abc, 3'd0, 16'h0000, 1'b0);
        add_entry(op_ldr, 16'h0120, 16'h0000, 3'd4, 16'h9abc, 1'b1);
        add_entry(op_str, 16'h0042, 16'h0130, 3'd0, 16'h0000, 1'b0);
        add_entry(op_sti, 16'h0042, 16'h2468, 3'd0, 16'h0000, 1'b0);
        add_entry(op_ldi, 16'h0042, 16'h0000, 3'd3, 16'h2468, 1'b1);
        add_entry(op_str, 16'h0140, 16'h0060, 3'd0, 16'h0000, 1'b0);
        add_entry(op_str, 16'h0060, 16'h1357, 3'd0, 16'h0000, 1'b0);
        add_entry(op_ldi, 16'h0140, 16'h0000, 3'd0, 16'h1357, 1'b1);
        add_entry(op_stb, 16'h0151, 16'h00c3, 3'd2, 16'h0000, 1'b0);
        add_entry(op_ldb, 16'h0151, 16'h0000, 3'd0, 16'hffc3, 1'b1);
        add_entry(op_lea, 16'h0000, 16'h0000, 3'd0, 16'h0000, 1'b0);
        // random store and load pairs, expected values from the model.
        for (int k = 0; k < RAND_PAIRS; k++) begin
            r = $random(seed);
            a = r[15:0] & 16'h01fe;
            r = $random(seed);
            d = r[15:0];
            r = $random(seed);
            add_entry(op_str, a, d, {1'b0, r[1:0]}, 16'h0000, 1'b0);
            if (r[2]) begin
                add_entry(op_ldb, a | {15'b0, r[3]}, 16'h0000, 3'd0, 16'h0000, 1'b0);
            end else begin
                add_entry(op_ldr, a, 16'h0000, 3'd0, 16'h0000, 1'b0);
            end
        end
    endtask

    task automatic drive_entry(input entry_t e);
        control_in = control_for(e.op);
        ir_in      = {e.op, 12'h000};
        addr_in    = e.addr;
        store_data = e.data;
        ext_stall  = (e.hold != 3'd0);
    endtask

    // ****************************************
    // main sequence.
    // ****************************************
    initial begin : main
        entry_t   e;
        lc3b_word expected;
        lc3b_word model_val;
        logic     first_stall;
        logic     ok;
        int       cycles;
        rst_n      = 1'b0;
        ext_stall  = 1'b0;
        control_in = '0;
        ir_in      = '0;
        addr_in    = '0;
        store_data = '0;
        seed       = 54;
        build_table();
        table_built = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        if (stall !== 1'b0) begin
            $display("ERROR stall after reset: expected %h, got %h", 1'b0, stall);
            fail_count = fail_count + 1;
        end else begin
            pass_count = pass_count + 1;
        end
        $display("reset: stall %h", stall);
        @(posedge clk);
        #1;
        for (int i = 0; i < table_q.size(); i++) begin
            e         = table_q[i];
            ok        = 1'b1;
            model_val = '0;
            if (is_mem(e.op)) begin
                model_apply(e, model_val);
            end
            expected = e.chk ? e.exp : model_val;
            if (e.chk && model_val !== e.exp) begin
                $display("entry %0d: table value %h does not match the reference model value %h",
                         i, e.exp, model_val);
                ok = 1'b0;
            end
            drive_entry(e);
            if (e.hold != 3'd0) begin
                repeat (e.hold) @(posedge clk);
                #1 ext_stall = 1'b0;
            end
            @(negedge clk);
            first_stall = stall;
            cycles      = 1;
            while (stall !== 1'b0) begin
                @(negedge clk);
                cycles = cycles + 1;
            end
            if (!is_mem(e.op) && first_stall !== 1'b0) begin
                $display("ERROR stall entry %0d: expected %h, got %h", i, 1'b0, first_stall);
                ok = 1'b0;
            end
            // a fresh access waits for its ack, so the stall starts high.
            if (is_mem(e.op) && e.hold == 3'd0 && first_stall !== 1'b1) begin
                $display("ERROR stall entry %0d: expected %h, got %h", i, 1'b1, first_stall);
                ok = 1'b0;
            end
            if (is_load(e.op) && load_data !== expected) begin
                $display("ERROR load_data entry %0d: expected %h, got %h",
                         i, expected, load_data);
                ok = 1'b0;
            end
            if (ok) begin
                pass_count = pass_count + 1;
            end else begin
                fail_count = fail_count + 1;
            end
            $display("entry %0d %s addr %h: %0d cycles, %s",
                     i, op_text(e.op), e.addr, cycles, ok ? "ok" : "failed");
            @(posedge clk);
            #1;
        end
        control_in = '0;
        ir_in      = '0;
        addr_in    = '0;
        store_data = '0;
        @(negedge clk);
        if (rty_seen != rty_expected) begin
            $display("ERROR rty_count: expected %h, got %h", rty_expected, rty_seen);
            fail_count = fail_count + 1;
        end else begin
            pass_count = pass_count + 1;
        end
        $display("retries: %0d", rty_seen);
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // worst case per entry is back-pressure plus two retried accesses.
    initial begin : watchdog
        longint limit;
        wait (table_built);
        limit = (longint'(table_q.size()) * longint'(ENTRY_CYCLES) + 12)
              * longint'(CLK_PERIOD);
        #(limit);
        $display("timeout: the run did not finish within %0d ns", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule : tb_mem_stage

`default_nettype wire

// ==== mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage import lc3b_mem_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ext_stall,
    input  lc3b_control_word control_in,
    input  lc3b_word         ir_in,
    input  lc3b_word         addr_in,
    input  lc3b_word         store_data,
    output lc3b_word         load_data,
    output logic             stall
);

    lc3b_data_memory_addr_mux_sel addr_sel;
    lc3b_mem_req                  mem_req;
    lc3b_word                     mem_rdata;
    logic                         mem_we;
    logic                         mem_ack;
    logic                         mem_rty;
    logic                         mdr_load;

    mem_access_controller controller (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .stall                    (ext_stall),
        .control_in               (control_in),
        .ir_in                    (ir_in),
        .data_memory_ack          (mem_ack),
        .data_memory_rty          (mem_rty),
        .data_memory_addr_mux_sel (addr_sel),
        .data_memory_we           (mem_we),
        .internal_mdr_load        (mdr_load),
        .request_stall            (stall)
    );

    mem_data_path data_path (
        .clk               (clk),
        .rst_n             (rst_n),
        .addr_sel          (addr_sel),
        .byte_access       (control_in.byte_access),
        .internal_mdr_load (mdr_load),
        .addr_in           (addr_in),
        .store_data        (store_data),
        .mem_rdata         (mem_rdata),
        .mem_req           (mem_req),
        .load_data         (load_data)
    );

    // strobe comes straight from the control word.
    data_memory dmem (
        .clk     (clk),
        .rst_n   (rst_n),
        .stb     (control_in.data_memory_access),
        .we      (mem_we),
        .mem_req (mem_req),
        .rdata   (mem_rdata),
        .ack     (mem_ack),
        .rty     (mem_rty)
    );

endmodule : mem_stage

`default_nettype wire

// ==== data_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_stage_cfg.svh"

module data_memory import lc3b_mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stb,
    input  logic        we,
    input  lc3b_mem_req mem_req,
    output lc3b_word    rdata,
    output logic        ack,
    output logic        rty
);

    localparam int ADDR_W = $clog2(`MEM_WORDS);
    localparam int CNT_W  = $clog2(`MEM_WAIT_STATES + 2);

    lc3b_word             mem [`MEM_WORDS];
    logic [`MEM_WORDS-1:0] retried;
    logic [CNT_W-1:0]     wait_cnt;
    logic [ADDR_W-1:0]    idx;
    logic                 respond;
    logic                 in_rty_region;

    // word index from the byte address.
    assign idx           = mem_req.addr[ADDR_W:1];
    assign in_rty_region = mem_req.addr[`MEM_RTY_ADDR_BIT];

    // ****************************************
    // handshake.
    // ****************************************
    assign respond = stb && (wait_cnt == CNT_W'(`MEM_WAIT_STATES));
    assign rty     = respond && in_rty_region && !retried[idx];
    assign ack     = respond && !rty;

    // counts idle cycles, restarts after every response.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (!stb || respond) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // one retry per word, the next try is acked.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retried <= '0;
        end else if (rty) begin
            retried[idx] <= 1'b1;
        end
    end

    // ****************************************
    // storage.
    // ****************************************
    assign rdata = mem[idx];

    // only the selected lanes change.
    always_ff @(posedge clk) begin
        if (ack && we) begin
            if (mem_req.byte_sel[0]) begin
                mem[idx][7:0] <= mem_req.wdata[7:0];
            end
            if (mem_req.byte_sel[1]) begin
                mem[idx][15:8] <= mem_req.wdata[15:8];
            end
        end
    end

    // a response needs the strobe held through the wait states.
    a_wait_states: assert property (@(posedge clk) disable iff (!rst_n)
        (ack || rty) |-> $past(stb, `MEM_WAIT_STATES));

endmodule : data_memory

`default_nettype wire

// ==== mem_data_path.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_data_path import lc3b_mem_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lc3b_data_memory_addr_mux_sel addr_sel,
    input  logic                         byte_access,
    input  logic                         internal_mdr_load,
    input  lc3b_word                     addr_in,
    input  lc3b_word                     store_data,
    input  lc3b_word                     mem_rdata,
    output lc3b_mem_req                  mem_req,
    output lc3b_word                     load_data
);

    lc3b_word   internal_mdr;
    lc3b_word   addr;
    logic [7:0] load_byte;

    // address mux.
    always_comb begin
        case (addr_sel)
            lc3b_data_memory_addr_mux_sel_internal_mdr: addr = internal_mdr;
            lc3b_data_memory_addr_mux_sel_zero:         addr = '0;
            default:                                    addr = addr_in;
        endcase
    end

    // holds the pointer between the two indirect phases.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            internal_mdr <= '0;
        end else if (internal_mdr_load) begin
            internal_mdr <= mem_rdata;
        end
    end

    // ****************************************
    // byte lanes.
    // ****************************************
    assign mem_req.addr     = addr;
    assign mem_req.wdata    = byte_access ? {2{store_data[7:0]}} : store_data;
    assign mem_req.byte_sel = byte_access ? (addr[0] ? 2'b10 : 2'b01) : 2'b11;

    // odd address picks the high lane, then sign extend.
    assign load_byte = addr[0] ? mem_rdata[15:8] : mem_rdata[7:0];
    assign load_data = byte_access ? {{8{load_byte[7]}}, load_byte} : mem_rdata;

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        !byte_access |-> !addr[0]);

endmodule : mem_data_path

`default_nettype wire

// ==== mem_access_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_access_controller import lc3b_mem_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,
    input  lc3b_control_word             control_in,
    input  lc3b_word                     ir_in,
    input  logic                         data_memory_ack,
    input  logic                         data_memory_rty,
    output lc3b_data_memory_addr_mux_sel data_memory_addr_mux_sel,
    output logic                         data_memory_we,
    output logic                         internal_mdr_load,
    output logic                         request_stall
);

    typedef enum logic {
        s_mem_access_1,
        s_mem_access_2
    } state_t;

    state_t     state;
    state_t     next_state;
    lc3b_opcode opcode;
    logic       is_indirect;
    logic       access_done;
    logic       state_stall;
    logic       memory_stall;

    assign opcode      = lc3b_opcode'(ir_in[15:12]);
    assign is_indirect = (opcode == op_ldi) || (opcode == op_sti);

    // an access is finished only by an ack that is not a retry.
    assign access_done = data_memory_ack & ~data_memory_rty;

    // ****************************************
    // stall generation.
    // ****************************************
    assign memory_stall  = control_in.data_memory_access
                         & (~data_memory_ack | data_memory_rty);
    assign request_stall = state_stall | memory_stall;

    always_comb begin
        data_memory_addr_mux_sel = control_in.data_memory_addr_mux_sel;
        data_memory_we           = control_in.data_memory_write_enable;
        internal_mdr_load        = 1'b0;
        state_stall              = 1'b0;
        case (state)
            s_mem_access_1: begin
                // pointer fetch, always a read.
                if (is_indirect) begin
                    data_memory_we    = 1'b0;
                    internal_mdr_load = access_done;
                    state_stall       = 1'b1;
                end
            end
            s_mem_access_2: begin
                data_memory_addr_mux_sel = lc3b_data_memory_addr_mux_sel_internal_mdr;
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            s_mem_access_1: if (is_indirect && access_done) next_state = s_mem_access_2;
            s_mem_access_2: if (access_done) next_state = s_mem_access_1;
            default:        next_state = s_mem_access_1;
        endcase
    end

    // state holds while the rest of the pipeline is stalled.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_mem_access_1;
        end else if (!stall) begin
            state <= next_state;
        end
    end

    // upstream holds the ir, so phase two only ever sees ldi or sti.
    a_phase2_indirect: assert property (@(posedge clk) disable iff (!rst_n)
        state == s_mem_access_2 |-> is_indirect);

    // the second access needs the strobe held, or phase two never ends.
    a_phase2_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        state == s_mem_access_2 |-> control_in.data_memory_access);

endmodule : mem_access_controller

`default_nettype wire

// ==== lc3b_mem_pkg.sv ====
`default_nettype none

package lc3b_mem_pkg;

    // data and address word.
    typedef logic [15:0] lc3b_word;

    // ****************************************
    // lc3b opcodes, ir[15:12].
    // ****************************************
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // source of the data memory address.
    typedef enum logic [1:0] {
        lc3b_data_memory_addr_mux_sel_alu          = 2'b00,
        lc3b_data_memory_addr_mux_sel_internal_mdr = 2'b01,
        lc3b_data_memory_addr_mux_sel_zero         = 2'b10
    } lc3b_data_memory_addr_mux_sel;

    // memory fields of the decoded control word.
    typedef struct packed {
        logic                         data_memory_access;
        logic                         data_memory_write_enable;
        lc3b_data_memory_addr_mux_sel data_memory_addr_mux_sel;
        logic                         byte_access;
    } lc3b_control_word;

    // request from datapath to data memory.
    typedef struct packed {
        lc3b_word   addr;
        lc3b_word   wdata;
        logic [1:0] byte_sel;
    } lc3b_mem_req;

endpackage : lc3b_mem_pkg

`default_nettype wire

// ==== mem_stage_cfg.svh ====
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// ****************************************
// data memory geometry and timing.
// ****************************************

// number of 16-bit words in the data memory.
`define MEM_WORDS 256

// idle cycles before each ack.
`define MEM_WAIT_STATES 2

// byte address bit that marks the retry region.
// first access to each word there gets one rty.
`define MEM_RTY_ADDR_BIT 8

`endif
